// File: Bender.yml
package:
  name: lc3b_system

sources:
  - hdl/lc3b_types.sv
  - hdl/wishbone.sv
  - hdl/cpu_ctrl_if.sv
  - hdl/cpu_datapath.sv
  - hdl/cpu_control.sv
  - hdl/cpu.sv
  - hdl/line_ram.sv
  - hdl/lc3b_system.sv
  - target: test
    files:
      - verification/lc3b_system_tb.sv

// File: hdl/cpu.sv
`timescale 1ns/1ps

module cpu (
	input logic reset,
	wishbone.master cpu_to_cache,
	output logic halted
);
	import lc3b_types::*;

	logic mem_resp;
	lc3b_word mem_rdata;
	logic mem_read;
	logic mem_write;
	lc3b_mem_wmask mem_byte_enable;
	lc3b_word mem_address;
	lc3b_word mem_wdata;
	lc3b_word mem_byte_mask;
	lc3b_line raw_dat;
	logic [3:0] byte_offset;

	cpu_ctrl_if ctrl_bus ();

	always_comb begin
		byte_offset = {mem_address[3:1], 1'b0}; // word lane, byte pick is in the datapath
		mem_byte_mask = {{8{mem_byte_enable[1]}}, {8{mem_byte_enable[0]}}};
		mem_resp = cpu_to_cache.ACK;
		raw_dat = cpu_to_cache.DAT_S >> (8 * byte_offset);
		mem_rdata = raw_dat[15:0];
		cpu_to_cache.CYC = mem_read | mem_write;
		cpu_to_cache.STB = mem_read | mem_write;
		cpu_to_cache.WE = mem_write;
		cpu_to_cache.SEL = lc3b_line_sel'({14'd0, mem_byte_enable}) << byte_offset;
		cpu_to_cache.ADR = mem_address[15:4];
		cpu_to_cache.DAT_M = lc3b_line'({112'd0, mem_wdata & mem_byte_mask})
			<< (8 * byte_offset);
	end

	cpu_datapath datapath_i (
		.clk(cpu_to_cache.CLK),
		.reset,
		.ctrl(ctrl_bus.datapath),
		.mem_rdata,
		.mem_address,
		.mem_wdata
	);

	cpu_control control_i (
		.clk(cpu_to_cache.CLK),
		.reset,
		.ctrl(ctrl_bus.control),
		.mem_resp,
		.mem_read,
		.mem_write,
		.mem_byte_enable,
		.halted
	);

endmodule : cpu

// File: hdl/cpu_control.sv
`timescale 1ns/1ps

module cpu_control (
	input logic clk,
	input logic reset,
	cpu_ctrl_if.control ctrl,
	input logic mem_resp,
	output logic mem_read,
	output logic mem_write,
	output lc3b_types::lc3b_mem_wmask mem_byte_enable,
	output logic halted
);
	import lc3b_types::*;

	typedef enum logic [10:0] {
		s_fetch1    = 11'h001,
		s_fetch2    = 11'h002,
		s_fetch3    = 11'h004,
		s_decode    = 11'h008,
		s_alu       = 11'h010,
		s_br        = 11'h020,
		s_calc_addr = 11'h040,
		s_ld_mem    = 11'h080,
		s_ld_wb     = 11'h100,
		s_st_mem    = 11'h200,
		s_halt      = 11'h400
	} state_t;

	state_t state;
	state_t next_state;
	logic byte_op;
	logic store_op;

	assign byte_op = (ctrl.opcode == op_ldb) || (ctrl.opcode == op_stb);
	assign store_op = (ctrl.opcode == op_str) || (ctrl.opcode == op_stb);

	always_ff @(posedge clk) begin
		if (reset)
			state <= s_fetch1;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		ctrl.load_pc = 1'b0;
		ctrl.load_ir = 1'b0;
		ctrl.load_regfile = 1'b0;
		ctrl.load_mar = 1'b0;
		ctrl.load_mdr = 1'b0;
		ctrl.load_cc = 1'b0;
		ctrl.pcmux_sel = pcmux_plus2;
		ctrl.alumux_sel = alumux_sr2;
		ctrl.regfilemux_sel = regmux_alu;
		ctrl.marmux_sel = marmux_alu;
		ctrl.mdrmux_sel = 1'b0;
		ctrl.storemux_sel = 1'b0;
		ctrl.aluop = alu_add;
		ctrl.mem_byte = byte_op;
		mem_read = 1'b0;
		mem_write = 1'b0;
		mem_byte_enable = 2'b11;
		halted = 1'b0;

		case (state)
			s_fetch1: begin
				ctrl.marmux_sel = marmux_pc;
				ctrl.load_mar = 1'b1;
				next_state = s_fetch2;
			end
			s_fetch2: begin
				mem_read = 1'b1;
				ctrl.load_mdr = mem_resp;
				if (mem_resp)
					next_state = s_fetch3;
			end
			s_fetch3: begin
				ctrl.load_ir = 1'b1;
				ctrl.load_pc = 1'b1;
				next_state = s_decode;
			end
			s_decode: begin
				case (ctrl.opcode)
					op_add, op_and, op_not: next_state = s_alu;
					op_br: next_state = s_br;
					op_ldr, op_ldb, op_str, op_stb: next_state = s_calc_addr;
					op_trap: next_state = s_halt;
					default: next_state = s_fetch1; // unsupported runs as a nop
				endcase
			end
			s_alu: begin
				case (ctrl.opcode)
					op_and: ctrl.aluop = alu_and;
					op_not: ctrl.aluop = alu_not;
					default: ctrl.aluop = alu_add;
				endcase
				ctrl.alumux_sel = ctrl.ir.alu_fmt.imm ? alumux_imm5 : alumux_sr2;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
				next_state = s_fetch1;
			end
			s_br: begin
				ctrl.pcmux_sel = pcmux_br;
				ctrl.load_pc = ctrl.branch_enable;
				next_state = s_fetch1;
			end
			s_calc_addr: begin
				ctrl.alumux_sel = byte_op ? alumux_off6b : alumux_off6w;
				ctrl.load_mar = 1'b1;
				ctrl.storemux_sel = 1'b1;
				ctrl.mdrmux_sel = 1'b1;
				ctrl.load_mdr = store_op; // store data staged with the address
				next_state = store_op ? s_st_mem : s_ld_mem;
			end
			s_ld_mem: begin
				mem_read = 1'b1;
				ctrl.load_mdr = mem_resp;
				if (mem_resp)
					next_state = s_ld_wb;
			end
			s_ld_wb: begin
				ctrl.regfilemux_sel = regmux_mem;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
				next_state = s_fetch1;
			end
			s_st_mem: begin
				mem_write = 1'b1;
				if (byte_op)
					mem_byte_enable = ctrl.mem_addr_lsb ? 2'b10 : 2'b01;
				if (mem_resp)
					next_state = s_fetch1;
			end
			s_halt: halted = 1'b1; // only reset leaves
			default: next_state = s_fetch1;
		endcase
	end

endmodule : cpu_control

// File: hdl/cpu_ctrl_if.sv
`timescale 1ns/1ps

interface cpu_ctrl_if;
	import lc3b_types::*;

	logic load_pc;
	logic load_ir;
	logic load_regfile;
	logic load_mar;
	logic load_mdr;
	logic load_cc;
	lc3b_sel pcmux_sel;
	lc3b_sel alumux_sel;
	lc3b_sel regfilemux_sel;
	lc3b_sel marmux_sel;
	logic mdrmux_sel; // 0 memory, 1 store data
	logic storemux_sel; // store source reg instead of src2
	lc3b_aluop aluop;
	logic mem_byte; // byte access, not word

	lc3b_opcode opcode;
	logic branch_enable;
	lc3b_instr ir;
	logic mem_addr_lsb;

	modport control (
		output load_pc, load_ir, load_regfile, load_mar, load_mdr, load_cc,
		output pcmux_sel, alumux_sel, regfilemux_sel, marmux_sel, mdrmux_sel,
		output storemux_sel, aluop, mem_byte,
		input opcode, branch_enable, ir, mem_addr_lsb
	);

	modport datapath (
		input load_pc, load_ir, load_regfile, load_mar, load_mdr, load_cc,
		input pcmux_sel, alumux_sel, regfilemux_sel, marmux_sel, mdrmux_sel,
		input storemux_sel, aluop, mem_byte,
		output opcode, branch_enable, ir, mem_addr_lsb
	);

endinterface : cpu_ctrl_if

// File: hdl/cpu_datapath.sv
`timescale 1ns/1ps

module cpu_datapath (
	input logic clk,
	input logic reset,
	cpu_ctrl_if.datapath ctrl,
	input lc3b_types::lc3b_word mem_rdata,
	output lc3b_types::lc3b_word mem_address,
	output lc3b_types::lc3b_word mem_wdata
);
	import lc3b_types::*;

	lc3b_word pc;
	lc3b_word mar;
	lc3b_word mdr;
	lc3b_instr ir;
	lc3b_word regs [8];
	logic [2:0] cc; // n z p

	lc3b_reg dest;
	lc3b_reg sr1;
	lc3b_reg sr2;
	lc3b_word sr1_out;
	lc3b_word sr2_out;
	lc3b_word imm5_sext;
	lc3b_word off6_byte;
	lc3b_word off6_word;
	lc3b_word br_offset;
	lc3b_word alu_b;
	lc3b_word alu_out;
	lc3b_word pc_next;
	lc3b_word mar_next;
	lc3b_word mdr_next;
	lc3b_word store_data;
	lc3b_word load_data;
	lc3b_word reg_data;

	always_comb begin
		dest = ir.alu_fmt.dest;
		sr1 = ir.mem_fmt.base; // same bits as src1
		sr2 = ctrl.storemux_sel ? ir.mem_fmt.dr_sr : ir.alu_fmt.imm5[2:0];
		sr1_out = regs[sr1];
		sr2_out = regs[sr2];

		imm5_sext = 16'(signed'(ir.alu_fmt.imm5));
		off6_byte = 16'(signed'(ir.mem_fmt.offset6));
		off6_word = {off6_byte[14:0], 1'b0};
		br_offset = 16'(signed'({ir.br_fmt.offset9, 1'b0}));
	end

	always_comb begin
		case (ctrl.alumux_sel)
			alumux_imm5: alu_b = imm5_sext;
			alumux_off6w: alu_b = off6_word;
			alumux_off6b: alu_b = off6_byte;
			default: alu_b = sr2_out;
		endcase

		case (ctrl.aluop)
			alu_add: alu_out = sr1_out + alu_b;
			alu_and: alu_out = sr1_out & alu_b;
			alu_not: alu_out = ~sr1_out;
			default: alu_out = sr1_out;
		endcase
	end

	always_comb begin
		pc_next = (ctrl.pcmux_sel == pcmux_br) ? pc + br_offset : pc + 16'd2;
		mar_next = (ctrl.marmux_sel == marmux_pc) ? pc : alu_out;
		store_data = ctrl.mem_byte ? {2{sr2_out[7:0]}} : sr2_out; // byte in both lanes
		mdr_next = ctrl.mdrmux_sel ? store_data : mem_rdata;

		if (ctrl.mem_byte)
			load_data = {8'h00, mar[0] ? mdr[15:8] : mdr[7:0]};
		else
			load_data = mdr;
		reg_data = (ctrl.regfilemux_sel == regmux_mem) ? load_data : alu_out;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= reset_pc;
			ir <= '0;
			cc <= 3'b010;
			for (int i = 0; i < 8; i++)
				regs[i] <= '0;
		end else begin
			if (ctrl.load_pc)
				pc <= pc_next;
			if (ctrl.load_ir)
				ir <= mdr;
			if (ctrl.load_regfile)
				regs[dest] <= reg_data;
			if (ctrl.load_cc)
				cc <= {reg_data[15], reg_data == '0, !reg_data[15] && reg_data != '0};
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl.load_mar)
			mar <= mar_next;
		if (ctrl.load_mdr)
			mdr <= mdr_next;
	end

	assign ctrl.ir = ir;
	assign ctrl.opcode = ir.alu_fmt.opcode;
	assign ctrl.branch_enable = |({ir.br_fmt.n, ir.br_fmt.z, ir.br_fmt.p} & cc);
	assign ctrl.mem_addr_lsb = mar[0];
	assign mem_address = mar;
	assign mem_wdata = mdr;

endmodule : cpu_datapath

// File: hdl/lc3b_system.sv
`timescale 1ns/1ps

module lc3b_system (
	input logic clk,
	input logic reset,
	input logic host_we,
	input lc3b_types::lc3b_line_addr host_addr,
	input lc3b_types::lc3b_line host_wdata,
	output lc3b_types::lc3b_line host_rdata,
	output logic halted
);

	wishbone bus ();

	assign bus.CLK = clk;

	cpu cpu_i (
		.reset,
		.cpu_to_cache(bus.master),
		.halted
	);

	line_ram ram_i (
		.reset,
		.bus(bus.slave),
		.host_we,
		.host_addr,
		.host_wdata,
		.host_rdata
	);

endmodule : lc3b_system

// File: hdl/lc3b_types.sv
package lc3b_types;

typedef logic [15:0] lc3b_word;
typedef logic [2:0] lc3b_reg;
typedef logic [1:0] lc3b_sel;
typedef logic [1:0] lc3b_mem_wmask;
typedef logic [127:0] lc3b_line;
typedef logic [15:0] lc3b_line_sel;
typedef logic [11:0] lc3b_line_addr;

typedef enum logic [3:0] {
	op_br   = 4'b0000,
	op_add  = 4'b0001,
	op_ldb  = 4'b0010,
	op_stb  = 4'b0011,
	op_and  = 4'b0101,
	op_ldr  = 4'b0110,
	op_str  = 4'b0111,
	op_not  = 4'b1001,
	op_trap = 4'b1111
} lc3b_opcode;

typedef enum logic [1:0] {
	alu_add,
	alu_and,
	alu_not,
	alu_pass
} lc3b_aluop;

typedef struct packed {
	lc3b_opcode opcode;
	lc3b_reg dest;
	lc3b_reg src1;
	logic imm;
	logic [4:0] imm5; // src2 sits in [2:0] when imm is clear
} lc3b_alu_fmt;

typedef struct packed {
	lc3b_opcode opcode;
	lc3b_reg dr_sr;
	lc3b_reg base;
	logic [5:0] offset6;
} lc3b_mem_fmt;

typedef struct packed {
	lc3b_opcode opcode;
	logic n;
	logic z;
	logic p;
	logic [8:0] offset9;
} lc3b_br_fmt;

typedef union packed {
	lc3b_alu_fmt alu_fmt;
	lc3b_mem_fmt mem_fmt;
	lc3b_br_fmt br_fmt;
} lc3b_instr;

localparam int ram_lines = 256;
localparam lc3b_word reset_pc = 16'h0000;

localparam lc3b_sel pcmux_plus2 = 2'd0;
localparam lc3b_sel pcmux_br = 2'd1;
localparam lc3b_sel marmux_alu = 2'd0;
localparam lc3b_sel marmux_pc = 2'd1;
localparam lc3b_sel alumux_sr2 = 2'd0;
localparam lc3b_sel alumux_imm5 = 2'd1;
localparam lc3b_sel alumux_off6w = 2'd2; // offset6 scaled to words
localparam lc3b_sel alumux_off6b = 2'd3;
localparam lc3b_sel regmux_alu = 2'd0;
localparam lc3b_sel regmux_mem = 2'd1;

endpackage : lc3b_types

// File: hdl/line_ram.sv
`timescale 1ns/1ps

module line_ram (
	input logic reset,
	wishbone.slave bus,
	input logic host_we,
	input lc3b_types::lc3b_line_addr host_addr,
	input lc3b_types::lc3b_line host_wdata,
	output lc3b_types::lc3b_line host_rdata
);
	import lc3b_types::*;

	localparam int index_bits = $clog2(ram_lines);
	localparam int line_bytes = $bits(lc3b_line_sel);

	lc3b_line mem [ram_lines];
	logic [index_bits-1:0] bus_index;
	logic [index_bits-1:0] host_index;
	logic access; // new request, not yet acknowledged
	logic ack;

	assign bus_index = bus.ADR[index_bits-1:0];
	assign host_index = host_addr[index_bits-1:0];
	assign access = bus.CYC && bus.STB && !ack;

	always_ff @(posedge bus.CLK) begin
		if (reset)
			ack <= 1'b0;
		else
			ack <= access;
	end

	always_ff @(posedge bus.CLK) begin
		if (host_we)
			mem[host_index] <= host_wdata;
		else if (access && bus.WE) begin
			for (int i = 0; i < line_bytes; i++)
				if (bus.SEL[i])
					mem[bus_index][8*i +: 8] <= bus.DAT_M[8*i +: 8];
		end
		if (access)
			bus.DAT_S <= mem[bus_index]; // valid alongside ack
		host_rdata <= mem[host_index];
	end

	assign bus.ACK = ack;

endmodule : line_ram

// File: hdl/wishbone.sv
`timescale 1ns/1ps

interface wishbone;
	import lc3b_types::*;

	logic CLK;
	logic CYC;
	logic STB;
	logic WE;
	lc3b_line_sel SEL;
	lc3b_line_addr ADR;
	lc3b_line DAT_M; // master to slave
	lc3b_line DAT_S; // slave to master
	logic ACK;

	modport master (
		input CLK, DAT_S, ACK,
		output CYC, STB, WE, SEL, ADR, DAT_M
	);

	modport slave (
		input CLK, CYC, STB, WE, SEL, ADR, DAT_M,
		output DAT_S, ACK
	);

endinterface : wishbone

// File: sim.f
hdl/lc3b_types.sv
hdl/wishbone.sv
hdl/cpu_ctrl_if.sv
hdl/cpu_datapath.sv
hdl/cpu_control.sv
hdl/cpu.sv
hdl/line_ram.sv
hdl/lc3b_system.sv
verification/lc3b_system_tb.sv

// File: verification/lc3b_stimulus.txt
# L line_addr line_data            line written through the host port in reset
# E line_addr line_data test_name  line expected after the processor halts
# program in lines 000 to 009 with its constants in line 000
L 000 0000000000008f0f1234014001000e07
L 001 7741167b77401642640462036a026c01
L 002 7745566c774456be77435642774216a7
L 003 738a638173886380774716827746967f
L 004 7393638573916384738f6383738d6382
L 005 73512376735023737396638773946386
L 006 06017f4808011e37337b357073522377
L 007 020116e57f4b0a017f4a040156e07f49
L 008 f0257f4f08017f4e06017f4d0c017f4c
L 009 00000000000000000000000000007f57
# data lines
L 010 717860675f564e453d342c231b120a01
L 011 c1c1c1c1c1c1c1c1c1c1c1c1c1c1c1c1
L 012 c2c2c2c2c2c2c2c2c2c2c2c2c2c2c2c2
L 013 0f1e2d3c4b5a69788796a5b4c3d2e1f0
L 014 00000000000000000000000000000000
L 015 11111111111111111111111111111111
L 016 d6d6d6d6d6d6d6d6d6d6d6d6d6d6d6d6
# expected lines
E 010 717860675f564e453d342c231b120a01 word_source
E 011 3d34c1c12c23c1c1c1c11b12c1c10a01 word_store_low
E 012 c2c27178c2c260675f56c2c24e45c2c2 word_store_high
E 013 0f1e2d3c875a69788796a5b4c3d2e10f byte_store
E 014 1e1eedcb00048f0e02048f16122fa143 alu_results
E 015 fff71111fff71111fff71111fff71111 branch_markers
E 016 d6d6d6d6d6d6d6d6d6d60087009600c3 byte_load_after_trap

// File: verification/lc3b_system_tb.sv
`timescale 1ns/1ps

module lc3b_system_tb;
	import lc3b_types::*;

	localparam int halt_limit = 2000;
	localparam int readback_limit = 4;
	localparam int name_chars = 24;

	logic clk;
	logic reset;
	logic host_we;
	lc3b_line_addr host_addr;
	lc3b_line host_wdata;
	lc3b_line host_rdata;
	logic halted;

	lc3b_line_addr load_addr [$];
	lc3b_line load_data [$];
	lc3b_line_addr exp_addr [$];
	lc3b_line exp_data [$];
	string exp_name [$];

	lc3b_system dut_i (
		.clk,
		.reset,
		.host_we,
		.host_addr,
		.host_wdata,
		.host_rdata,
		.halted
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("STATUS: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic check_line(input string name, input lc3b_line expected,
			input lc3b_line actual);
		if (actual !== expected)
			abort_run($sformatf("error %s expected %h actual %h", name, expected, actual));
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected)
			abort_run($sformatf("error %s expected %b actual %b", name, expected, actual));
	endtask

	// fscanf leaves the token right aligned with leading nul bytes
	function automatic string name_text(input logic [8*name_chars-1:0] raw);
		string text;
		int i;
		text = "";
		for (i = name_chars - 1; i >= 0; i--)
			if (raw[8*i +: 8] != 8'h00)
				text = {text, $sformatf("%c", raw[8*i +: 8])};
		return text;
	endfunction

	task automatic read_stimulus();
		int fd;
		int code;
		logic [8*8-1:0] kind;
		logic [8*128-1:0] rest;
		lc3b_line_addr addr;
		lc3b_line data;
		logic [8*name_chars-1:0] name;
		fd = $fopen("verification/lc3b_stimulus.txt", "r");
		if (fd == 0)
			abort_run("cannot open verification/lc3b_stimulus.txt");
		while ($fscanf(fd, "%s", kind) == 1) begin
			if (kind == "#") begin
				code = $fgets(rest, fd); // rest of a comment line
			end else if (kind == "L") begin
				code = $fscanf(fd, "%h %h", addr, data);
				if (code != 2)
					abort_run("malformed load record in stimulus file");
				load_addr.push_back(addr);
				load_data.push_back(data);
			end else if (kind == "E") begin
				name = '0;
				code = $fscanf(fd, "%h %h %s", addr, data, name);
				if (code != 3)
					abort_run("malformed expect record in stimulus file");
				exp_addr.push_back(addr);
				exp_data.push_back(data);
				exp_name.push_back(name_text(name));
			end else begin
				abort_run("unknown record kind in stimulus file");
			end
		end
		$fclose(fd);
	endtask

	initial begin
		int cycles;
		int i;
		reset = 1'b1;
		host_we = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		read_stimulus();

		repeat (2) @(posedge clk);
		for (i = 0; i < load_addr.size(); i++) begin
			@(posedge clk);
			host_we <= 1'b1;
			host_addr <= load_addr[i];
			host_wdata <= load_data[i];
		end
		@(posedge clk);
		host_we <= 1'b0; // last line lands on this edge
		@(posedge clk);
		reset <= 1'b0;

		cycles = 0;
		@(negedge clk);
		while (!halted && cycles < halt_limit) begin
			@(negedge clk);
			cycles++;
		end
		if (!halted)
			abort_run("processor never halted");

		for (i = 0; i < exp_addr.size(); i++) begin
			@(posedge clk);
			host_addr <= exp_addr[i];
			cycles = 0;
			@(negedge clk);
			while (host_rdata !== exp_data[i] && cycles < readback_limit) begin
				@(negedge clk);
				cycles++;
			end
			if ($isunknown(host_rdata))
				abort_run($sformatf("readback of line %h stalled with unknown data",
					exp_addr[i]));
			check_line(exp_name[i], exp_data[i], host_rdata);
		end
		check_flag("halt_held", 1'b1, halted);

		$display("STATUS: PASS");
		$finish;
	end

endmodule : lc3b_system_tb
